/* rtl/rf_pkg.sv */
/*
 * Sizes and types shared by the banked register file.
 * Word address bits 1:0 pick the bank and bits 8:2 pick the row.
 * The bank count and the bank depth must be powers of two.
 */
package rf_pkg;

   // defaults for the top-level parameters
   parameter int WORD_W     = 32;
   parameter int NUM_BANKS  = 4;
   parameter int BANK_DEPTH = 128;

   // derived address fields
   parameter int OFS_W  = $clog2(NUM_BANKS);
   parameter int ROW_W  = $clog2(BANK_DEPTH);
   parameter int ADDR_W = OFS_W + ROW_W;

   // one register word
   typedef logic [WORD_W-1:0] word_t;

   // word address, with the bank offset in the low bits
   typedef logic [ADDR_W-1:0] addr_t;

   // row inside one bank
   typedef logic [ROW_W-1:0] row_t;

   // one enable bit per word of a write
   typedef logic [NUM_BANKS-1:0] wr_mask_t;

   // four words, used by rd0 and by the write port
   typedef logic [NUM_BANKS*WORD_W-1:0] wide_t;

   // two words, used by rd1
   typedef logic [2*WORD_W-1:0] narrow_t;

endpackage

/* rtl/rf_bank.sv */
/*
 * One bank with two registered read ports and one write port.
 * A read and a write to the same row at one edge return the old word.
 * The memory has no reset and holds X until written.
 */
module rf_bank #(
   parameter int WORD_W     = rf_pkg::WORD_W,
   parameter int BANK_DEPTH = rf_pkg::BANK_DEPTH
) (
   input  logic          clk,

   input  rf_pkg::row_t  rd_a_row,
   output rf_pkg::word_t rd_a_data,

   input  rf_pkg::row_t  rd_b_row,
   output rf_pkg::word_t rd_b_data,

   input  logic          we,
   input  rf_pkg::row_t  wr_row,
   input  rf_pkg::word_t wdata
);

   import rf_pkg::*;

   logic [WORD_W-1:0] mem [BANK_DEPTH];

   // the row field must cover the whole bank
   if (BANK_DEPTH != 2**ROW_W || WORD_W != $bits(word_t))
   begin : g_size_check
      $error("rf_bank size does not match the row and word types");
   end

   // nonblocking reads see the word from before the write
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[wr_row] <= wdata;
      end
      rd_a_data <= mem[rd_a_row];
      rd_b_data <= mem[rd_b_row];
   end

   // the decoder must never enable a bank with an unknown row or word
   a_wr_known : assert property (
      @(posedge clk) we |-> !$isunknown({wr_row, wdata})
   )
   else
      $error("rf_bank write with unknown row or data");

endmodule

/* rtl/wr_decode.sv */
/*
 * Write steering for the four banks.
 * Legal writes are mask 0001 at any offset, 0011 at offset 0 or 2,
 * 1111 at offset 0, and 0000 (no write). Any other write is dropped
 * and wr_reject goes high for the following cycle.
 */
module wr_decode #(
   parameter int WORD_W    = rf_pkg::WORD_W,
   parameter int NUM_BANKS = rf_pkg::NUM_BANKS
) (
   input  logic                             clk,
   input  logic                             rst_n,

   input  rf_pkg::addr_t                    wr_addr,
   input  rf_pkg::wr_mask_t                 wr_en,
   input  rf_pkg::wide_t                    wr_data,

   output logic [NUM_BANKS-1:0]             bank_we,
   output logic [NUM_BANKS-1:0][WORD_W-1:0] bank_wdata,
   output rf_pkg::row_t                     wr_row,
   output logic                             wr_reject
);

   import rf_pkg::*;

   localparam int LOG_BANKS = $clog2(NUM_BANKS);

   logic [OFS_W-1:0] ofs;
   logic [OFS_W-1:0] lane;
   logic             legal;
   logic             reject_d;

   if ($bits(wide_t) != NUM_BANKS*WORD_W || $bits(wr_mask_t) != NUM_BANKS)
   begin : g_size_check
      $error("wr_decode payload width does not match the bank layout");
   end

   assign ofs = wr_addr[OFS_W-1:0];

   // legal writes are aligned, so every word shares the base row
   assign wr_row = wr_addr[ADDR_W-1:OFS_W];

   // a run of 2**k low mask bits needs an offset aligned to 2**k
   always_comb
   begin
      legal = (wr_en == '0);
      for (int k = 0; k <= LOG_BANKS; k++)
      begin
         if (wr_en == NUM_BANKS'((1 << (1 << k)) - 1) && (ofs % (1 << k)) == 0)
         begin
            legal = 1'b1;
         end
      end
   end

   assign reject_d = !legal;

   // bank b takes word j of the write where b = offset + j
   always_comb
   begin
      lane = '0;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
         lane          = OFS_W'(b) - ofs;
         bank_we[b]    = legal & wr_en[lane];
         bank_wdata[b] = wr_data[lane*WORD_W +: WORD_W];
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_reject <= 1'b0;
      end
      else
      begin
         wr_reject <= reject_d;
      end
   end

   // one bank per mask bit for a legal write and none for a rejected one
   a_we_count : assert property (
      @(posedge clk) disable iff (!rst_n)
      $countones(bank_we) == (reject_d ? 0 : $countones(wr_en))
   )
   else
      $error("wr_decode enabled the wrong number of banks");

endmodule

/* rtl/rd_port.sv */
/*
 * One read port across all banks, returning LANES consecutive words.
 * Addresses wrap at the top of the word space.
 * Data follows the address by one cycle and lane 0 is the base word.
 * The payload type must be a whole number of words, at most one per bank.
 */
module rd_port #(
   parameter int  WORD_W      = rf_pkg::WORD_W,
   parameter int  NUM_BANKS   = rf_pkg::NUM_BANKS,
   parameter type read_data_t = rf_pkg::wide_t
) (
   input  logic                             clk,
   input  logic                             rst_n,

   input  rf_pkg::addr_t                    addr,

   output rf_pkg::row_t [NUM_BANKS-1:0]     bank_row,
   input  logic [NUM_BANKS-1:0][WORD_W-1:0] bank_data,

   output read_data_t                       rd_data
);

   import rf_pkg::*;

   localparam int LANES = $bits(read_data_t) / WORD_W;

   addr_t            lane_addr;
   logic [OFS_W-1:0] ofs_q;
   logic [OFS_W-1:0] src;

   if (LANES * WORD_W != $bits(read_data_t) || LANES > NUM_BANKS ||
       NUM_BANKS != 2**OFS_W)
   begin : g_size_check
      $error("rd_port payload does not fit the bank layout");
   end

   // banks that no lane touches just get the base row
   always_comb
   begin
      lane_addr = addr;
      for (int b = 0; b < NUM_BANKS; b++)
      begin
         bank_row[b] = addr[ADDR_W-1:OFS_W];
      end
      for (int j = 0; j < LANES; j++)
      begin
         lane_addr = addr + ADDR_W'(j);
         bank_row[lane_addr[OFS_W-1:0]] = lane_addr[ADDR_W-1:OFS_W];
      end
   end

   // the offset travels alongside the bank read
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ofs_q <= '0;
      end
      else
      begin
         ofs_q <= addr[OFS_W-1:0];
      end
   end

   // rotate so that lane j comes from bank ofs_q + j
   always_comb
   begin
      src = ofs_q;
      for (int j = 0; j < LANES; j++)
      begin
         src = ofs_q + OFS_W'(j);
         rd_data[j*WORD_W +: WORD_W] = bank_data[src];
      end
   end

   // an unknown offset would scramble every lane of the next result
   a_ofs_known : assert property (
      @(posedge clk) disable iff (!rst_n) !$isunknown(ofs_q)
   )
   else
      $error("rd_port offset register is unknown");

endmodule

/* rtl/banked_regfile.sv */
/*
 * 512 x 32-bit register file in four interleaved banks.
 * rd0 returns four words and rd1 two words, both one cycle after the
 * address, read-first against a write at the same edge.
 * Writes follow the mask rules of wr_decode. Contents are not reset.
 */
module banked_regfile #(
   parameter int WORD_W     = rf_pkg::WORD_W,
   parameter int NUM_BANKS  = rf_pkg::NUM_BANKS,
   parameter int BANK_DEPTH = rf_pkg::BANK_DEPTH
) (
   input  logic             clk,
   input  logic             rst_n,

   input  rf_pkg::addr_t    rd0_addr,
   output rf_pkg::wide_t    rd0_data,

   input  rf_pkg::addr_t    rd1_addr,
   output rf_pkg::narrow_t  rd1_data,

   input  rf_pkg::addr_t    wr_addr,
   input  rf_pkg::wr_mask_t wr_en,
   input  rf_pkg::wide_t    wr_data,
   output logic             wr_reject
);

   import rf_pkg::*;

   logic [NUM_BANKS-1:0]             bank_we;
   logic [NUM_BANKS-1:0][WORD_W-1:0] bank_wdata;
   row_t                             wr_row;

   // rd0 uses read port a of every bank, rd1 uses port b
   row_t [NUM_BANKS-1:0]             rd0_row;
   logic [NUM_BANKS-1:0][WORD_W-1:0] rd0_bank_data;
   row_t [NUM_BANKS-1:0]             rd1_row;
   logic [NUM_BANKS-1:0][WORD_W-1:0] rd1_bank_data;

   wr_decode #(
      .WORD_W    (WORD_W),
      .NUM_BANKS (NUM_BANKS)
   ) u_wr_decode (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_addr    (wr_addr),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .bank_we    (bank_we),
      .bank_wdata (bank_wdata),
      .wr_row     (wr_row),
      .wr_reject  (wr_reject)
   );

   for (genvar b = 0; b < NUM_BANKS; b++)
   begin : g_bank
      rf_bank #(
         .WORD_W     (WORD_W),
         .BANK_DEPTH (BANK_DEPTH)
      ) u_bank (
         .clk       (clk),
         .rd_a_row  (rd0_row[b]),
         .rd_a_data (rd0_bank_data[b]),
         .rd_b_row  (rd1_row[b]),
         .rd_b_data (rd1_bank_data[b]),
         .we        (bank_we[b]),
         .wr_row    (wr_row),
         .wdata     (bank_wdata[b])
      );
   end

   rd_port #(
      .WORD_W      (WORD_W),
      .NUM_BANKS   (NUM_BANKS),
      .read_data_t (wide_t)
   ) rd0_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (rd0_addr),
      .bank_row  (rd0_row),
      .bank_data (rd0_bank_data),
      .rd_data   (rd0_data)
   );

   rd_port #(
      .WORD_W      (WORD_W),
      .NUM_BANKS   (NUM_BANKS),
      .read_data_t (narrow_t)
   ) rd1_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (rd1_addr),
      .bank_row  (rd1_row),
      .bank_data (rd1_bank_data),
      .rd_data   (rd1_data)
   );

endmodule

/* test/rf_checker.sv */
/*
 * Reference model and comparator for the banked register file.
 * Words never written are not checked. Expected read data is taken
 * before the write of the same edge and compared one edge later.
 */
module rf_checker (
   input  logic             clk,
   input  logic             rst_n,
   input  rf_pkg::addr_t    rd0_addr,
   input  rf_pkg::wide_t    rd0_data,
   input  rf_pkg::addr_t    rd1_addr,
   input  rf_pkg::narrow_t  rd1_data,
   input  rf_pkg::addr_t    wr_addr,
   input  rf_pkg::wr_mask_t wr_en,
   input  rf_pkg::wide_t    wr_data,
   input  logic             wr_reject,
   output int               mismatch_count,
   output int               edges_seen,
   output logic             active
);

   timeunit 1ns;
   timeprecision 1ps;

   import rf_pkg::*;

   localparam int WORDS  = 512;
   localparam int WIDE_N = 4;
   localparam int NARR_N = 2;

   word_t model   [WORDS];
   bit    written [WORDS];

   word_t exp0 [WIDE_N];
   bit    chk0 [WIDE_N];
   word_t exp1 [NARR_N];
   bit    chk1 [NARR_N];
   logic  exp_rej;

   int    errors  = 0;
   int    seen    = 0;
   logic  running = 1'b0;

   assign mismatch_count = errors;
   assign edges_seen     = seen;
   assign active         = running;

   function automatic bit write_is_legal(input addr_t addr, input wr_mask_t mask);
      logic [1:0] ofs;
      ofs = addr[1:0];
      case (mask)
         4'b0000, 4'b0001: return 1'b1;
         4'b0011:          return (ofs == 2'd0) || (ofs == 2'd2);
         4'b1111:          return ofs == 2'd0;
         default:          return 1'b0;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      errors++;
      $display("Mismatch at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
   endtask

   always @(posedge clk)
   begin : sample
      int idx;

      if (!rst_n)
      begin
         if (wr_reject !== 1'b0)
         begin
            report_mismatch("wr_reject", 32'd0, {31'd0, wr_reject});
         end
         exp_rej = 1'b0;
         chk0    = '{default: 1'b0};
         chk1    = '{default: 1'b0};
         running = 1'b0;
      end
      else
      begin
         running = 1'b1;
         seen++;

         // results of the previous edge
         if (wr_reject !== exp_rej)
         begin
            report_mismatch("wr_reject", {31'd0, exp_rej}, {31'd0, wr_reject});
         end
         for (int k = 0; k < WIDE_N; k++)
         begin
            if (chk0[k] && rd0_data[k*WORD_W +: WORD_W] !== exp0[k])
            begin
               report_mismatch($sformatf("rd0_data word %0d", k), exp0[k],
                               rd0_data[k*WORD_W +: WORD_W]);
            end
         end
         for (int k = 0; k < NARR_N; k++)
         begin
            if (chk1[k] && rd1_data[k*WORD_W +: WORD_W] !== exp1[k])
            begin
               report_mismatch($sformatf("rd1_data word %0d", k), exp1[k],
                               rd1_data[k*WORD_W +: WORD_W]);
            end
         end

         // expectations for the next edge, from memory before this write
         exp_rej = !write_is_legal(wr_addr, wr_en);
         for (int k = 0; k < WIDE_N; k++)
         begin
            idx     = (int'(rd0_addr) + k) % WORDS;
            exp0[k] = model[idx];
            chk0[k] = written[idx];
         end
         for (int k = 0; k < NARR_N; k++)
         begin
            idx     = (int'(rd1_addr) + k) % WORDS;
            exp1[k] = model[idx];
            chk1[k] = written[idx];
         end

         // word j of a legal write lands at address wr_addr + j
         if (write_is_legal(wr_addr, wr_en))
         begin
            for (int j = 0; j < WIDE_N; j++)
            begin
               if (wr_en[j])
               begin
                  idx          = (int'(wr_addr) + j) % WORDS;
                  model[idx]   = wr_data[j*WORD_W +: WORD_W];
                  written[idx] = 1'b1;
               end
            end
         end
      end
   end

endmodule

/* test/tb_banked_regfile.sv */
/*
 * Testbench top for the banked register file.
 * Applies a fixed table of operations, one per cycle, driven on the
 * falling clock edge. Checking is done by rf_checker.
 */
module tb_banked_regfile;

   timeunit 1ns;
   timeprecision 1ps;

   import rf_pkg::*;

   // data-select codes for a table entry
   localparam logic DS_RAND = 1'b0;
   localparam logic DS_ONES = 1'b1;

   typedef struct packed {
      addr_t    wr_addr;
      wr_mask_t wr_en;
      logic     dsel;
      addr_t    rd0_addr;
      addr_t    rd1_addr;
   } op_t;

   localparam int NUM_OPS = 22;

   // wr_addr, wr_en, data select, rd0_addr, rd1_addr
   localparam op_t OPS [NUM_OPS] = '{
      '{9'd0,   4'b1111, DS_RAND, 9'd0,   9'd0},
      '{9'd0,   4'b0000, DS_RAND, 9'd0,   9'd2},
      '{9'd5,   4'b0001, DS_RAND, 9'd0,   9'd0},
      '{9'd7,   4'b0001, DS_RAND, 9'd4,   9'd0},
      '{9'd8,   4'b0011, DS_RAND, 9'd4,   9'd5},
      '{9'd10,  4'b0011, DS_RAND, 9'd8,   9'd7},
      '{9'd4,   4'b0001, DS_RAND, 9'd8,   9'd8},
      '{9'd6,   4'b0001, DS_RAND, 9'd4,   9'd9},
      '{9'd0,   4'b0000, DS_RAND, 9'd4,   9'd10},
      '{9'd0,   4'b0000, DS_RAND, 9'd0,   9'd11},
      // upper row, then wrapped reads
      '{9'd508, 4'b1111, DS_RAND, 9'd0,   9'd3},
      '{9'd0,   4'b0000, DS_RAND, 9'd510, 9'd511},
      '{9'd509, 4'b0001, DS_RAND, 9'd508, 9'd1},
      // illegal writes
      '{9'd9,   4'b0011, DS_RAND, 9'd509, 9'd508},
      '{9'd2,   4'b1111, DS_RAND, 9'd8,   9'd0},
      '{9'd4,   4'b0101, DS_RAND, 9'd0,   9'd2},
      '{9'd0,   4'b0000, DS_RAND, 9'd4,   9'd9},
      // read and write of one word at the same edge
      '{9'd5,   4'b0001, DS_ONES, 9'd4,   9'd5},
      '{9'd0,   4'b0000, DS_RAND, 9'd4,   9'd5},
      '{9'd8,   4'b1111, DS_RAND, 9'd8,   9'd10},
      '{9'd0,   4'b0000, DS_RAND, 9'd8,   9'd10},
      '{9'd0,   4'b0000, DS_RAND, 9'd509, 9'd1}
   };

   logic        clk = 1'b0;
   logic        rst_n;
   addr_t       rd0_addr;
   wide_t       rd0_data;
   addr_t       rd1_addr;
   narrow_t     rd1_data;
   addr_t       wr_addr;
   wr_mask_t    wr_en;
   wide_t       wr_data;
   logic        wr_reject;

   logic [31:0] rand_state;
   int          timeouts;
   int          mismatch_count;
   int          edges_seen;
   logic        active;

   always
   begin
      #10 clk = ~clk;
   end

   banked_regfile DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd0_addr  (rd0_addr),
      .rd0_data  (rd0_data),
      .rd1_addr  (rd1_addr),
      .rd1_data  (rd1_data),
      .wr_addr   (wr_addr),
      .wr_en     (wr_en),
      .wr_data   (wr_data),
      .wr_reject (wr_reject)
   );

   rf_checker u_checker (
      .clk            (clk),
      .rst_n          (rst_n),
      .rd0_addr       (rd0_addr),
      .rd0_data       (rd0_data),
      .rd1_addr       (rd1_addr),
      .rd1_data       (rd1_data),
      .wr_addr        (wr_addr),
      .wr_en          (wr_en),
      .wr_data        (wr_data),
      .wr_reject      (wr_reject),
      .mismatch_count (mismatch_count),
      .edges_seen     (edges_seen),
      .active         (active)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic apply_op(input op_t op);
      for (int k = 0; k < NUM_BANKS; k++)
      begin
         if (op.dsel == DS_ONES)
         begin
            wr_data[k*WORD_W +: WORD_W] = '1;
         end
         else
         begin
            rand_state = xorshift32(rand_state);
            wr_data[k*WORD_W +: WORD_W] = rand_state;
         end
      end
      wr_addr  = op.wr_addr;
      wr_en    = op.wr_en;
      rd0_addr = op.rd0_addr;
      rd1_addr = op.rd1_addr;
   endtask

   initial
   begin
      int wait_cycles;
      int target;

      rst_n      = 1'b0;
      rd0_addr   = '0;
      rd1_addr   = '0;
      wr_addr    = '0;
      wr_en      = '0;
      wr_data    = '0;
      rand_state = 32'd64706;
      timeouts   = 0;

      for (int i = 0; i < 10; i++)
      begin
         @(posedge clk);
      end
      @(negedge clk);
      rst_n = 1'b1;

      wait_cycles = 0;
      while (!active && wait_cycles < 5)
      begin
         @(negedge clk);
         wait_cycles++;
      end

      if (!active)
      begin
         $display("Timeout: the checker never saw reset released");
         timeouts++;
      end
      else
      begin
         for (int i = 0; i < NUM_OPS; i++)
         begin
            @(negedge clk);
            apply_op(OPS[i]);
         end
         @(negedge clk);
         wr_en = '0;

         // one more edge compares the last entry
         target      = edges_seen + 1;
         wait_cycles = 0;
         while (edges_seen < target && wait_cycles < 10)
         begin
            @(negedge clk);
            wait_cycles++;
         end
         if (edges_seen < target)
         begin
            $display("Timeout: the checker did not finish the last entry");
            timeouts++;
         end
      end

      $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeouts);
      if (mismatch_count == 0 && timeouts == 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
rtl/rf_pkg.sv
rtl/rf_bank.sv
rtl/wr_decode.sv
rtl/rd_port.sv
rtl/banked_regfile.sv
test/rf_checker.sv
test/tb_banked_regfile.sv

/* Bender.yml */
package:
  name: banked_regfile

sources:
  # RTL in compile order
  - files:
      - rtl/rf_pkg.sv
      - rtl/rf_bank.sv
      - rtl/wr_decode.sv
      - rtl/rd_port.sv
      - rtl/banked_regfile.sv

  # testbench
  - target: test
    files:
      - test/rf_checker.sv
      - test/tb_banked_regfile.sv
